//--- logic/hydra_consts.svh
`ifndef HYDRA_CONSTS_SVH
`define HYDRA_CONSTS_SVH

// one bank per input port
`define NUM_PORTS 4
`define PORT_W 2

// priority 7 is served first
`define NUM_PRIOS 8
`define PRIO_W 3

`define DATA_W 16
`define PAGES_PER_BANK 16
`define PAGE_W 4
// global page address is {bank, page}
`define ADDR_W 6
`define CNT_W 5
`define ALMOST_FULL_PAGES 4

`endif

//--- logic/hydra_pkt_pkg.sv
`include "hydra_consts.svh"

package hydra_pkt_pkg;

    // header word carried on the sop cycle
    typedef struct packed {
        logic [`DATA_W-`PRIO_W-`PORT_W-1:0] rsvd;
        logic [`PRIO_W-1:0]                 prior;
        logic [`PORT_W-1:0]                 dest;
    } pkt_header_s;

    // one bus word seen as header or as raw payload
    typedef union packed {
        pkt_header_s        hdr;
        logic [`DATA_W-1:0] raw;
    } pkt_word_u;

endpackage

//--- logic/hydra_sel_pkg.sv
`include "hydra_consts.svh"

package hydra_sel_pkg;

    // lowest set bit, 0 when the mask is empty
    function automatic logic [`PAGE_W-1:0] first_set(input logic [`PAGES_PER_BANK-1:0] mask);
        logic [`PAGE_W-1:0] idx;
        idx = '0;
        for (int i = `PAGES_PER_BANK - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = `PAGE_W'(i);
            end
        end
        return idx;
    endfunction

    // highest set bit
    function automatic logic [`PRIO_W-1:0] last_set(input logic [`NUM_PRIOS-1:0] mask);
        logic [`PRIO_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < `NUM_PRIOS; i++) begin
            if (mask[i]) begin
                idx = `PRIO_W'(i);
            end
        end
        return idx;
    endfunction

endpackage

//--- logic/port_wr_frontend.sv
`timescale 1ns/1ps
`include "hydra_consts.svh"

module port_wr_frontend (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_sop,
    input  logic                     wr_vld,
    input  logic                     wr_eop,
    input  hydra_pkt_pkg::pkt_word_u wr_data,
    input  logic [`ADDR_W-1:0]       alloc_page,
    input  logic                     join_grant,
    output logic                     buf_wr,
    output logic                     buf_first,
    output logic                     buf_last,
    output logic [`DATA_W-1:0]       buf_word,
    output logic                     join_req,
    output logic [`PORT_W-1:0]       join_dest,
    output logic [`PRIO_W-1:0]       join_prior,
    output logic [`ADDR_W-1:0]       join_head,
    output logic [`ADDR_W-1:0]       join_tail
);
    import hydra_pkt_pkg::*;

    pkt_header_s        hdr;
    logic               first_pend;
    logic [`PORT_W-1:0] cur_dest;
    logic [`PRIO_W-1:0] cur_prior;
    logic [`ADDR_W-1:0] cur_head;

    assign hdr = wr_data.hdr;

    // payload goes straight to the bank and the header word is dropped
    assign buf_wr    = wr_vld && !wr_sop;
    assign buf_first = buf_wr && first_pend;
    assign buf_last  = buf_wr && wr_eop;
    assign buf_word  = wr_data.raw;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first_pend <= 1'b0;
        end else if (wr_sop) begin
            first_pend <= 1'b1;
        end else if (buf_wr) begin
            first_pend <= 1'b0;
        end
    end

    // header fields and head page of the packet in flight
    always_ff @(posedge clk) begin
        if (wr_sop) begin
            cur_dest  <= hdr.dest;
            cur_prior <= hdr.prior;
        end
        if (buf_first) begin
            cur_head <= alloc_page;
        end
    end

    // held until the arbiter takes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            join_req <= 1'b0;
        end else if (buf_last) begin
            join_req <= 1'b1;
        end else if (join_grant) begin
            join_req <= 1'b0;
        end
    end

    // snapshot at eop so the next sop leaves the pending join alone
    always_ff @(posedge clk) begin
        if (buf_last) begin
            join_dest  <= cur_dest;
            join_prior <= cur_prior;
            join_head  <= buf_first ? alloc_page : cur_head;
            join_tail  <= alloc_page;
        end
    end

endmodule

//--- logic/page_buffer.sv
`timescale 1ns/1ps
`include "hydra_consts.svh"

module page_buffer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [`NUM_PORTS-1:0]              buf_wr,
    input  logic [`NUM_PORTS-1:0]              buf_first,
    input  logic [`NUM_PORTS-1:0]              buf_last,
    input  logic [`NUM_PORTS-1:0][`DATA_W-1:0] buf_word,
    input  logic                               link_en,
    input  logic [`ADDR_W-1:0]                 link_from,
    input  logic [`ADDR_W-1:0]                 link_to,
    input  logic [`NUM_PORTS-1:0][`ADDR_W-1:0] rd_page,
    input  logic [`NUM_PORTS-1:0]              rd_take,
    output logic [`NUM_PORTS-1:0][`ADDR_W-1:0] alloc_page,
    output logic [`NUM_PORTS-1:0][`DATA_W-1:0] rd_word,
    output logic [`NUM_PORTS-1:0]              rd_last,
    output logic [`NUM_PORTS-1:0][`ADDR_W-1:0] rd_next,
    output logic                               full,
    output logic                               almost_full
);
    import hydra_sel_pkg::*;

    localparam int NUM_PAGES = `NUM_PORTS * `PAGES_PER_BANK;

    logic [`DATA_W-1:0] word_mem [NUM_PAGES];
    logic               last_mem [NUM_PAGES];
    logic [`ADDR_W-1:0] jump_mem [NUM_PAGES];

    logic [`NUM_PORTS-1:0][`PAGES_PER_BANK-1:0] free_map;
    logic [`NUM_PORTS-1:0][`PAGE_W-1:0]         prev_page;
    logic [`NUM_PORTS-1:0][`CNT_W-1:0]          free_cnt;
    logic [`NUM_PORTS-1:0]                      bank_full;
    logic [`NUM_PORTS-1:0]                      bank_low;

    // lowest free page of each bank
    always_comb begin
        for (int b = 0; b < `NUM_PORTS; b++) begin
            alloc_page[b] = {`PORT_W'(b), first_set(free_map[b])};
            free_cnt[b]   = `CNT_W'($countones(free_map[b]));
            bank_full[b]  = free_cnt[b] == '0;
            bank_low[b]   = free_cnt[b] <= `CNT_W'(`ALMOST_FULL_PAGES);
        end
    end

    assign full        = |bank_full;
    assign almost_full = |bank_low;

    // writes claim a page and reads hand one back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map <= '1;
        end else begin
            for (int b = 0; b < `NUM_PORTS; b++) begin
                if (buf_wr[b]) begin
                    free_map[b][alloc_page[b][`PAGE_W-1:0]] <= 1'b0;
                end
            end
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (rd_take[p]) begin
                    free_map[rd_page[p][`ADDR_W-1:`PAGE_W]][rd_page[p][`PAGE_W-1:0]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < `NUM_PORTS; b++) begin
            if (buf_wr[b]) begin
                word_mem[alloc_page[b]] <= buf_word[b];
                last_mem[alloc_page[b]] <= buf_last[b];
                prev_page[b]            <= alloc_page[b][`PAGE_W-1:0];
                // chain from the previous page of the same packet
                if (!buf_first[b]) begin
                    jump_mem[{`PORT_W'(b), prev_page[b]}] <= alloc_page[b];
                end
            end
        end
        // tail of one packet to head of the next in a queue
        if (link_en) begin
            jump_mem[link_from] <= link_to;
        end
    end

    always_comb begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            rd_word[p] = word_mem[rd_page[p]];
            rd_last[p] = last_mem[rd_page[p]];
            rd_next[p] = jump_mem[rd_page[p]];
        end
    end

endmodule

//--- logic/join_arbiter.sv
`timescale 1ns/1ps
`include "hydra_consts.svh"

module join_arbiter (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [`NUM_PORTS-1:0]              join_req,
    input  logic [`NUM_PORTS-1:0][`PORT_W-1:0] join_dest,
    input  logic [`NUM_PORTS-1:0][`PRIO_W-1:0] join_prior,
    input  logic [`NUM_PORTS-1:0][`ADDR_W-1:0] join_head,
    input  logic [`NUM_PORTS-1:0][`ADDR_W-1:0] join_tail,
    output logic [`NUM_PORTS-1:0]              join_grant,
    output logic                               enq_vld,
    output logic [`PORT_W-1:0]                 enq_dest,
    output logic [`PRIO_W-1:0]                 enq_prior,
    output logic [`ADDR_W-1:0]                 enq_head,
    output logic [`ADDR_W-1:0]                 enq_tail
);
    import hydra_sel_pkg::*;

    logic [`PORT_W-1:0]      rr_ptr;
    logic [2*`NUM_PORTS-1:0] req_twice;
    logic [`PAGE_W-1:0]      offset;
    logic [`PORT_W-1:0]      win;

    // rotate so the pointer's port sits at bit 0
    assign req_twice = {join_req, join_req} >> rr_ptr;
    assign offset    = first_set(`PAGES_PER_BANK'(req_twice[`NUM_PORTS-1:0]));
    // wraps in PORT_W bits
    assign win        = rr_ptr + offset[`PORT_W-1:0];
    assign join_grant = (|join_req) ? (`NUM_PORTS'(1) << win) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enq_vld <= 1'b0;
            rr_ptr  <= '0;
        end else begin
            enq_vld <= |join_req;
            if (|join_req) begin
                rr_ptr <= win + `PORT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|join_req) begin
            enq_dest  <= join_dest[win];
            enq_prior <= join_prior[win];
            enq_head  <= join_head[win];
            enq_tail  <= join_tail[win];
        end
    end

endmodule

//--- logic/queue_manager.sv
`timescale 1ns/1ps
`include "hydra_consts.svh"

module queue_manager (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               enq_vld,
    input  logic [`PORT_W-1:0]                                 enq_dest,
    input  logic [`PRIO_W-1:0]                                 enq_prior,
    input  logic [`ADDR_W-1:0]                                 enq_head,
    input  logic [`ADDR_W-1:0]                                 enq_tail,
    input  logic [`NUM_PORTS-1:0]                              pop,
    input  logic [`NUM_PORTS-1:0][`PRIO_W-1:0]                 pop_prior,
    input  logic [`NUM_PORTS-1:0][`ADDR_W-1:0]                 pop_next,
    output logic [`NUM_PORTS-1:0][`NUM_PRIOS-1:0]              q_nonempty,
    output logic [`NUM_PORTS-1:0][`NUM_PRIOS-1:0][`ADDR_W-1:0] q_head,
    output logic                                               link_en,
    output logic [`ADDR_W-1:0]                                 link_from,
    output logic [`ADDR_W-1:0]                                 link_to
);
    logic [`NUM_PORTS-1:0][`NUM_PRIOS-1:0][`ADDR_W-1:0] tail;
    logic [`NUM_PORTS-1:0][`NUM_PRIOS-1:0][`CNT_W-1:0]  cnt;
    logic [`NUM_PORTS-1:0][`NUM_PRIOS-1:0]              enq_hit;
    logic [`NUM_PORTS-1:0][`NUM_PRIOS-1:0]              pop_hit;
    logic [`CNT_W-1:0]                                  enq_cnt;
    logic                                               enq_fresh;

    always_comb begin
        for (int d = 0; d < `NUM_PORTS; d++) begin
            for (int p = 0; p < `NUM_PRIOS; p++) begin
                enq_hit[d][p]    = enq_vld && enq_dest == d && enq_prior == p;
                pop_hit[d][p]    = pop[d] && pop_prior[d] == p;
                q_nonempty[d][p] = cnt[d][p] != '0;
            end
        end
    end

    // target queue is empty or drains in this same cycle
    assign enq_cnt   = cnt[enq_dest][enq_prior];
    assign enq_fresh = enq_cnt == '0
        || (enq_cnt == `CNT_W'(1) && pop_hit[enq_dest][enq_prior]);

    assign link_en   = enq_vld && !enq_fresh;
    assign link_from = tail[enq_dest][enq_prior];
    assign link_to   = enq_head;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            for (int d = 0; d < `NUM_PORTS; d++) begin
                for (int p = 0; p < `NUM_PRIOS; p++) begin
                    cnt[d][p] <= cnt[d][p] + `CNT_W'(enq_hit[d][p]) - `CNT_W'(pop_hit[d][p]);
                end
            end
        end
    end

    // head follows the jump table on pop and restarts on a fresh enqueue
    always_ff @(posedge clk) begin
        for (int d = 0; d < `NUM_PORTS; d++) begin
            for (int p = 0; p < `NUM_PRIOS; p++) begin
                if (pop_hit[d][p]) begin
                    q_head[d][p] <= pop_next[d];
                end
                if (enq_hit[d][p]) begin
                    tail[d][p] <= enq_tail;
                    if (enq_fresh) begin
                        q_head[d][p] <= enq_head;
                    end
                end
            end
        end
    end

endmodule

//--- logic/port_rd_frontend.sv
`timescale 1ns/1ps
`include "hydra_consts.svh"

module port_rd_frontend (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ready,
    input  logic [`NUM_PRIOS-1:0]               q_nonempty,
    input  logic [`NUM_PRIOS-1:0][`ADDR_W-1:0]  q_head,
    input  logic [`DATA_W-1:0]                  rd_word,
    input  logic                                rd_last,
    input  logic [`ADDR_W-1:0]                  rd_next,
    output logic                                rd_sop,
    output logic                                rd_vld,
    output logic                                rd_eop,
    output logic [`DATA_W-1:0]                  rd_data,
    output logic [`ADDR_W-1:0]                  rd_page,
    output logic                                rd_take,
    output logic                                pop,
    output logic [`PRIO_W-1:0]                  pop_prior,
    output logic [`ADDR_W-1:0]                  pop_next
);
    import hydra_sel_pkg::*;

    logic               busy;
    logic               start;
    logic               active;
    logic [`PRIO_W-1:0] best_prior;
    logic [`PRIO_W-1:0] cur_prior;
    logic [`ADDR_W-1:0] cur_page;

    // strict priority among non-empty queues
    assign best_prior = last_set(q_nonempty);
    assign start      = !busy && ready && |q_nonempty;
    assign active     = busy || start;

    // head page is read in the cycle ready is seen
    assign rd_page   = busy ? cur_page : q_head[best_prior];
    assign rd_take   = active;
    assign pop       = active && rd_last;
    assign pop_prior = busy ? cur_prior : best_prior;
    assign pop_next  = rd_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rd_sop <= 1'b0;
            rd_vld <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            busy   <= active && !rd_last;
            rd_sop <= start;
            rd_vld <= active;
            rd_eop <= active && rd_last;
        end
    end

    // one page per cycle along the jump chain
    always_ff @(posedge clk) begin
        if (active) begin
            rd_data  <= rd_word;
            cur_page <= rd_next;
        end
        if (start) begin
            cur_prior <= best_prior;
        end
    end

endmodule

//--- logic/hydra_top.sv
`timescale 1ns/1ps
`include "hydra_consts.svh"

module hydra_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [`NUM_PORTS-1:0]              wr_sop,
    input  logic [`NUM_PORTS-1:0]              wr_vld,
    input  logic [`NUM_PORTS-1:0]              wr_eop,
    input  logic [`NUM_PORTS-1:0][`DATA_W-1:0] wr_data,
    input  logic [`NUM_PORTS-1:0]              ready,
    output logic [`NUM_PORTS-1:0]              rd_sop,
    output logic [`NUM_PORTS-1:0]              rd_vld,
    output logic [`NUM_PORTS-1:0]              rd_eop,
    output logic [`NUM_PORTS-1:0][`DATA_W-1:0] rd_data,
    output logic                               full,
    output logic                               almost_full
);
    // write side
    logic [`NUM_PORTS-1:0]              buf_wr;
    logic [`NUM_PORTS-1:0]              buf_first;
    logic [`NUM_PORTS-1:0]              buf_last;
    logic [`NUM_PORTS-1:0][`DATA_W-1:0] buf_word;
    logic [`NUM_PORTS-1:0][`ADDR_W-1:0] alloc_page;
    logic [`NUM_PORTS-1:0]              join_req;
    logic [`NUM_PORTS-1:0]              join_grant;
    logic [`NUM_PORTS-1:0][`PORT_W-1:0] join_dest;
    logic [`NUM_PORTS-1:0][`PRIO_W-1:0] join_prior;
    logic [`NUM_PORTS-1:0][`ADDR_W-1:0] join_head;
    logic [`NUM_PORTS-1:0][`ADDR_W-1:0] join_tail;

    // queue side
    logic                                               enq_vld;
    logic [`PORT_W-1:0]                                 enq_dest;
    logic [`PRIO_W-1:0]                                 enq_prior;
    logic [`ADDR_W-1:0]                                 enq_head;
    logic [`ADDR_W-1:0]                                 enq_tail;
    logic                                               link_en;
    logic [`ADDR_W-1:0]                                 link_from;
    logic [`ADDR_W-1:0]                                 link_to;
    logic [`NUM_PORTS-1:0][`NUM_PRIOS-1:0]              q_nonempty;
    logic [`NUM_PORTS-1:0][`NUM_PRIOS-1:0][`ADDR_W-1:0] q_head;

    // read side
    logic [`NUM_PORTS-1:0][`ADDR_W-1:0] rd_page;
    logic [`NUM_PORTS-1:0]              rd_take;
    logic [`NUM_PORTS-1:0][`DATA_W-1:0] rd_word;
    logic [`NUM_PORTS-1:0]              rd_last;
    logic [`NUM_PORTS-1:0][`ADDR_W-1:0] rd_next;
    logic [`NUM_PORTS-1:0]              pop;
    logic [`NUM_PORTS-1:0][`PRIO_W-1:0] pop_prior;
    logic [`NUM_PORTS-1:0][`ADDR_W-1:0] pop_next;

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
        port_wr_frontend i_wr (
            .clk(clk), .rst_n(rst_n),
            .wr_sop(wr_sop[i]), .wr_vld(wr_vld[i]), .wr_eop(wr_eop[i]), .wr_data(wr_data[i]),
            .alloc_page(alloc_page[i]), .join_grant(join_grant[i]),
            .buf_wr(buf_wr[i]), .buf_first(buf_first[i]), .buf_last(buf_last[i]),
            .buf_word(buf_word[i]), .join_req(join_req[i]), .join_dest(join_dest[i]),
            .join_prior(join_prior[i]), .join_head(join_head[i]), .join_tail(join_tail[i])
        );

        port_rd_frontend i_rd (
            .clk(clk), .rst_n(rst_n), .ready(ready[i]),
            .q_nonempty(q_nonempty[i]), .q_head(q_head[i]),
            .rd_word(rd_word[i]), .rd_last(rd_last[i]), .rd_next(rd_next[i]),
            .rd_sop(rd_sop[i]), .rd_vld(rd_vld[i]), .rd_eop(rd_eop[i]), .rd_data(rd_data[i]),
            .rd_page(rd_page[i]), .rd_take(rd_take[i]),
            .pop(pop[i]), .pop_prior(pop_prior[i]), .pop_next(pop_next[i])
        );
    end

    page_buffer i_buf (
        .clk(clk), .rst_n(rst_n),
        .buf_wr(buf_wr), .buf_first(buf_first), .buf_last(buf_last), .buf_word(buf_word),
        .link_en(link_en), .link_from(link_from), .link_to(link_to),
        .rd_page(rd_page), .rd_take(rd_take), .alloc_page(alloc_page),
        .rd_word(rd_word), .rd_last(rd_last), .rd_next(rd_next),
        .full(full), .almost_full(almost_full)
    );

    join_arbiter i_arb (
        .clk(clk), .rst_n(rst_n),
        .join_req(join_req), .join_dest(join_dest), .join_prior(join_prior),
        .join_head(join_head), .join_tail(join_tail), .join_grant(join_grant),
        .enq_vld(enq_vld), .enq_dest(enq_dest), .enq_prior(enq_prior),
        .enq_head(enq_head), .enq_tail(enq_tail)
    );

    queue_manager i_qm (
        .clk(clk), .rst_n(rst_n),
        .enq_vld(enq_vld), .enq_dest(enq_dest), .enq_prior(enq_prior),
        .enq_head(enq_head), .enq_tail(enq_tail),
        .pop(pop), .pop_prior(pop_prior), .pop_next(pop_next),
        .q_nonempty(q_nonempty), .q_head(q_head),
        .link_en(link_en), .link_from(link_from), .link_to(link_to)
    );

endmodule

//--- verification/hydra_assert.sv
`timescale 1ns/1ps
`include "hydra_consts.svh"

module hydra_assert (
    input logic                  clk,
    input logic                  rst_n,
    input logic [`NUM_PORTS-1:0] rd_sop,
    input logic [`NUM_PORTS-1:0] rd_vld,
    input logic [`NUM_PORTS-1:0] rd_eop,
    input logic                  full,
    input logic                  almost_full
);
    // zero free pages is also below the low threshold
    assert property (@(posedge clk) disable iff (!rst_n) full |-> almost_full)
        else $error("full is set while almost_full is clear");

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
        assert property (@(posedge clk) disable iff (!rst_n) rd_sop[i] |-> rd_vld[i])
            else $error("rd_sop without rd_vld on port %0d", i);
        assert property (@(posedge clk) disable iff (!rst_n) rd_eop[i] |-> rd_vld[i])
            else $error("rd_eop without rd_vld on port %0d", i);
        // words of one packet come back to back
        assert property (@(posedge clk) disable iff (!rst_n)
            (rd_vld[i] && !rd_eop[i]) |=> rd_vld[i])
            else $error("rd_vld dropped inside a packet on port %0d", i);
    end

endmodule

bind hydra_top hydra_assert i_assert (
    .clk(clk),
    .rst_n(rst_n),
    .rd_sop(rd_sop),
    .rd_vld(rd_vld),
    .rd_eop(rd_eop),
    .full(full),
    .almost_full(almost_full)
);

//--- verification/hydra_tb.sv
`timescale 1ns/1ps
`include "hydra_consts.svh"

module hydra_tb;
    import hydra_pkt_pkg::*;

    localparam int QUEUE_WAIT = `NUM_PORTS + 2;
    localparam int MAX_WAIT   = 20;

    logic                               clk;
    logic                               rst_n;
    logic [`NUM_PORTS-1:0]              wr_sop;
    logic [`NUM_PORTS-1:0]              wr_vld;
    logic [`NUM_PORTS-1:0]              wr_eop;
    logic [`NUM_PORTS-1:0][`DATA_W-1:0] wr_data;
    logic [`NUM_PORTS-1:0]              ready;
    logic [`NUM_PORTS-1:0]              rd_sop;
    logic [`NUM_PORTS-1:0]              rd_vld;
    logic [`NUM_PORTS-1:0]              rd_eop;
    logic [`NUM_PORTS-1:0][`DATA_W-1:0] rd_data;
    logic                               full;
    logic                               almost_full;

    logic [31:0]        lcg_state;
    // expected payload per packet slot
    logic [`DATA_W-1:0] pkt_mem [16][8];
    int                 pkt_len [16];
    // packet staged on each input port
    logic [`DATA_W-1:0] hdr_word [`NUM_PORTS];
    int                 hdr_slot [`NUM_PORTS];

    hydra_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_vld(wr_vld), .wr_eop(wr_eop), .wr_data(wr_data),
        .ready(ready), .rd_sop(rd_sop), .rd_vld(rd_vld), .rd_eop(rd_eop),
        .rd_data(rd_data), .full(full), .almost_full(almost_full)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [`DATA_W-1:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // header keeps random reserved bits
    task automatic load_packet(input int port, input int slot, input int dest,
                               input int prior, input int len);
        pkt_word_u hw;
        hw.raw       = next_rand();
        hw.hdr.dest  = dest[`PORT_W-1:0];
        hw.hdr.prior = prior[`PRIO_W-1:0];
        hdr_word[port] = hw.raw;
        hdr_slot[port] = slot;
        pkt_len[slot]  = len;
        for (int w = 0; w < len; w++) begin
            pkt_mem[slot][w] = next_rand();
        end
    endtask

    // all ports in mask start on the same cycle
    task automatic drive_packets(input logic [`NUM_PORTS-1:0] mask);
        int max_len;
        max_len = 0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (mask[p] && pkt_len[hdr_slot[p]] > max_len) begin
                max_len = pkt_len[hdr_slot[p]];
            end
        end
        @(posedge clk);
        #2;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (mask[p]) begin
                wr_sop[p]  = 1'b1;
                wr_vld[p]  = 1'b1;
                wr_data[p] = hdr_word[p];
            end
        end
        for (int w = 0; w < max_len; w++) begin
            @(posedge clk);
            #2;
            wr_sop = '0;
            wr_vld = '0;
            wr_eop = '0;
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (mask[p] && w < pkt_len[hdr_slot[p]]) begin
                    wr_vld[p]  = 1'b1;
                    wr_data[p] = pkt_mem[hdr_slot[p]][w];
                    wr_eop[p]  = w == pkt_len[hdr_slot[p]] - 1;
                end
            end
        end
        @(posedge clk);
        #2;
        wr_vld = '0;
        wr_eop = '0;
        // joins land in their queues within this window
        repeat (QUEUE_WAIT) @(posedge clk);
        #2;
    endtask

    task automatic receive_packet(input int port, input int slot, input bit mid_ready);
        int waited;
        int len;
        len     = pkt_len[slot];
        waited  = 0;
        ready[port] = 1'b1;
        while (rd_sop[port] !== 1'b1 && waited < MAX_WAIT) begin
            @(posedge clk);
            #2;
            ready[port] = 1'b0;
            waited++;
        end
        assert (rd_sop[port] === 1'b1) else begin
            $display("no packet started on port %0d within %0d cycles of ready", port, MAX_WAIT);
            abort_run();
        end
        check_eq($sformatf("rd_sop[%0d] latency", port), 1, waited);
        for (int w = 0; w < len; w++) begin
            check_eq($sformatf("rd_vld[%0d]", port), 1, rd_vld[port]);
            check_eq($sformatf("rd_sop[%0d]", port), w == 0, rd_sop[port]);
            check_eq($sformatf("rd_eop[%0d]", port), w == len - 1, rd_eop[port]);
            check_eq($sformatf("rd_data[%0d]", port), pkt_mem[slot][w], rd_data[port]);
            // a second ready while the port is busy
            ready[port] = mid_ready && w == 1;
            @(posedge clk);
            #2;
        end
        ready[port] = 1'b0;
        check_eq($sformatf("rd_vld[%0d]", port), 0, rd_vld[port]);
    endtask

    task automatic expect_quiet(input int port, input int cycles);
        for (int n = 0; n < cycles; n++) begin
            check_eq($sformatf("rd_sop[%0d]", port), 0, rd_sop[port]);
            check_eq($sformatf("rd_vld[%0d]", port), 0, rd_vld[port]);
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_flags(input bit exp_almost, input bit exp_full);
        check_eq("almost_full", exp_almost, almost_full);
        check_eq("full", exp_full, full);
    endtask

    task automatic test_single_packet();
        load_packet(0, 0, 2, 3, 5);
        drive_packets(4'b0001);
        receive_packet(2, 0, 1'b0);
    endtask

    task automatic test_priority();
        load_packet(0, 0, 1, 1, 3);
        drive_packets(4'b0001);
        load_packet(3, 1, 1, 6, 4);
        drive_packets(4'b1000);
        receive_packet(1, 1, 1'b0);
        receive_packet(1, 0, 1'b0);
    endtask

    task automatic test_concat_order();
        for (int i = 0; i < 3; i++) begin
            load_packet(2, i, 0, 4, 2 + i);
            drive_packets(4'b0100);
        end
        for (int i = 0; i < 3; i++) begin
            receive_packet(0, i, 1'b0);
        end
    endtask

    task automatic test_simultaneous_joins();
        // equal lengths so all four eops and join requests coincide
        load_packet(0, 0, 3, 2, 4);
        load_packet(1, 1, 3, 5, 4);
        load_packet(2, 2, 3, 7, 4);
        load_packet(3, 3, 3, 0, 4);
        drive_packets(4'b1111);
        // descending priority 7, 5, 2, 0
        receive_packet(3, 2, 1'b0);
        receive_packet(3, 1, 1'b0);
        receive_packet(3, 0, 1'b0);
        receive_packet(3, 3, 1'b0);
    endtask

    task automatic test_fill_flags();
        int used;
        for (int i = 0; i < 4; i++) begin
            load_packet(1, i, 0, 3, 4);
            drive_packets(4'b0010);
            used = 4 * (i + 1);
            check_flags(`PAGES_PER_BANK - used <= `ALMOST_FULL_PAGES,
                        used == `PAGES_PER_BANK);
        end
        for (int i = 0; i < 4; i++) begin
            receive_packet(0, i, 1'b0);
        end
        check_flags(1'b0, 1'b0);
    endtask

    task automatic test_ignored_ready();
        ready[1] = 1'b1;
        @(posedge clk);
        #2;
        ready[1] = 1'b0;
        expect_quiet(1, 4);
        load_packet(3, 0, 1, 2, 4);
        drive_packets(4'b1000);
        load_packet(3, 1, 1, 2, 3);
        drive_packets(4'b1000);
        receive_packet(1, 0, 1'b1);
        // second packet waits for its own ready
        expect_quiet(1, 4);
        receive_packet(1, 1, 1'b0);
    endtask

    initial begin
        lcg_state = 32'h9324dd27;
        rst_n     = 1'b0;
        wr_sop    = '0;
        wr_vld    = '0;
        wr_eop    = '0;
        wr_data   = '0;
        ready     = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_flags(1'b0, 1'b0);
        test_single_packet();
        test_priority();
        test_concat_order();
        test_simultaneous_joins();
        test_fill_flags();
        test_ignored_ready();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/hydra_pkt_pkg.sv
logic/hydra_sel_pkg.sv
logic/port_wr_frontend.sv
logic/page_buffer.sv
logic/join_arbiter.sv
logic/queue_manager.sv
logic/port_rd_frontend.sv
logic/hydra_top.sv
verification/hydra_assert.sv
verification/hydra_tb.sv
